/* hw/dspm_pkg.sv */
// Shared constants and types; the scratchpad window must be aligned to its own size in bytes
`default_nettype none

package dspm_pkg;

  // ------------------------------
  // Widths and port count
  // ------------------------------
  localparam int unsigned NUM_PORTS = 2;
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = DATA_W / 8;

  typedef logic [ADDR_W-1:0] paddr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BE_W-1:0]   be_t;

  // ------------------------------
  // Scratchpad address map
  // ------------------------------
  localparam paddr_t      SPM_BASE  = 32'h1000_0000;
  localparam int unsigned SPM_WORDS = 256;
  localparam int unsigned SPM_IDX_W = 8;

  // Word index inside the scratchpad
  typedef logic [SPM_IDX_W-1:0] spm_idx_t;

  // Owner of an arbiter grant, one bit covers two ports
  typedef logic [0:0] port_sel_t;

  // ------------------------------
  // Router encodings
  // ------------------------------
  typedef enum logic {
    DEST_SPM    = 1'b0,
    DEST_BYPASS = 1'b1
  } req_dest_t;

  typedef enum logic [1:0] {
    RT_IDLE  = 2'd0,
    RT_ISSUE = 2'd1,
    RT_WAIT  = 2'd2
  } router_state_t;

endpackage

`default_nettype wire

/* hw/port_router.sv */
// One request in flight per port; the request payload is held until the target accepts it
`timescale 1ns/1ps
`default_nettype none

module port_router (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  // Requester side
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  input  wire dspm_pkg::paddr_t    req_addr_i,
  input  wire logic                req_we_i,
  input  wire dspm_pkg::be_t       req_be_i,
  input  wire dspm_pkg::word_t     req_wdata_i,
  output logic                     rsp_valid_o,
  input  wire logic                rsp_ready_i,
  output dspm_pkg::word_t          rsp_rdata_o,
  // Scratchpad arbiter side
  output logic                     spm_req_valid_o,
  input  wire logic                spm_req_ready_i,
  input  wire logic                spm_rsp_valid_i,
  output logic                     spm_rsp_ready_o,
  input  wire dspm_pkg::word_t     spm_rsp_rdata_i,
  // Bypass arbiter side
  output logic                     byp_req_valid_o,
  input  wire logic                byp_req_ready_i,
  input  wire logic                byp_rsp_valid_i,
  output logic                     byp_rsp_ready_o,
  input  wire dspm_pkg::word_t     byp_rsp_rdata_i,
  // Held request, shared by both arbiters
  output dspm_pkg::paddr_t         fwd_addr_o,
  output logic                     fwd_we_o,
  output dspm_pkg::be_t            fwd_be_o,
  output dspm_pkg::word_t          fwd_wdata_o
);

  import dspm_pkg::*;

  router_state_t state_q, state_d;
  req_dest_t     req_dest;
  req_dest_t     dest_q;
  logic          issue_ready;
  logic          to_spm;

  // Window check as a single unsigned compare, addresses below the base wrap high
  assign req_dest = ((req_addr_i - SPM_BASE) < paddr_t'(SPM_WORDS * BE_W)) ?
                    DEST_SPM : DEST_BYPASS;

  assign to_spm = (dest_q == DEST_SPM);

  // ------------------------------
  // Handshake steering
  // ------------------------------
  assign req_ready_o     = (state_q == RT_IDLE);
  assign spm_req_valid_o = (state_q == RT_ISSUE) && to_spm;
  assign byp_req_valid_o = (state_q == RT_ISSUE) && !to_spm;
  assign issue_ready     = to_spm ? spm_req_ready_i : byp_req_ready_i;

  // Response passes straight through, back-pressure included
  assign rsp_valid_o     = (state_q == RT_WAIT) &&
                           (to_spm ? spm_rsp_valid_i : byp_rsp_valid_i);
  assign rsp_rdata_o     = to_spm ? spm_rsp_rdata_i : byp_rsp_rdata_i;
  assign spm_rsp_ready_o = (state_q == RT_WAIT) && to_spm && rsp_ready_i;
  assign byp_rsp_ready_o = (state_q == RT_WAIT) && !to_spm && rsp_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RT_IDLE: begin
        if (req_valid_i) begin
          state_d = RT_ISSUE;
        end
      end
      RT_ISSUE: begin
        if (issue_ready) begin
          state_d = RT_WAIT;
        end
      end
      RT_WAIT: begin
        if (rsp_valid_o && rsp_ready_i) begin
          state_d = RT_IDLE;
        end
      end
      default: begin
        state_d = RT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RT_IDLE;
      dest_q  <= DEST_SPM;
    end else begin
      state_q <= state_d;
      if (req_valid_i && req_ready_o) begin
        dest_q <= req_dest;
      end
    end
  end

  // Payload capture on the accepting edge
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      fwd_addr_o  <= req_addr_i;
      fwd_we_o    <= req_we_i;
      fwd_be_o    <= req_be_i;
      fwd_wdata_o <= req_wdata_i;
    end
  end

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
// Lower port index always wins; the grant stays with one port until its response is taken
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire logic                                          clk_i,
  input  wire logic                                          arst_n_i,
  // Requester side, one entry per port
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]                in_req_valid_i,
  output logic [dspm_pkg::NUM_PORTS-1:0]                     in_req_ready_o,
  input  wire dspm_pkg::paddr_t [dspm_pkg::NUM_PORTS-1:0]    in_addr_i,
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]                in_we_i,
  input  wire dspm_pkg::be_t [dspm_pkg::NUM_PORTS-1:0]       in_be_i,
  input  wire dspm_pkg::word_t [dspm_pkg::NUM_PORTS-1:0]     in_wdata_i,
  output logic [dspm_pkg::NUM_PORTS-1:0]                     in_rsp_valid_o,
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]                in_rsp_ready_i,
  output dspm_pkg::word_t [dspm_pkg::NUM_PORTS-1:0]          in_rsp_rdata_o,
  // Target side
  output logic                                               out_req_valid_o,
  input  wire logic                                          out_req_ready_i,
  output dspm_pkg::paddr_t                                   out_addr_o,
  output logic                                               out_we_o,
  output dspm_pkg::be_t                                      out_be_o,
  output dspm_pkg::word_t                                    out_wdata_o,
  input  wire logic                                          out_rsp_valid_i,
  output logic                                               out_rsp_ready_o,
  input  wire dspm_pkg::word_t                               out_rsp_rdata_i
);

  import dspm_pkg::*;

  logic      lock_q;
  port_sel_t owner_q;
  port_sel_t sel;

  // Fixed priority, scan from the top so the lowest valid index ends up selected
  always_comb begin
    sel = '0;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (in_req_valid_i[i]) begin
        sel = port_sel_t'(i);
      end
    end
  end

  // ------------------------------
  // Request path, no register
  // ------------------------------
  assign out_req_valid_o = !lock_q && (|in_req_valid_i);
  assign out_addr_o      = in_addr_i[sel];
  assign out_we_o        = in_we_i[sel];
  assign out_be_o        = in_be_i[sel];
  assign out_wdata_o     = in_wdata_i[sel];

  always_comb begin
    in_req_ready_o = '0;
    if (!lock_q) begin
      in_req_ready_o[sel] = out_req_ready_i;
    end
  end

  // ------------------------------
  // Response path to the owner
  // ------------------------------
  always_comb begin
    in_rsp_valid_o = '0;
    if (lock_q) begin
      in_rsp_valid_o[owner_q] = out_rsp_valid_i;
    end
  end

  assign out_rsp_ready_o = lock_q && in_rsp_ready_i[owner_q];
  // Data fans out to all ports, only the owner sees a valid
  assign in_rsp_rdata_o  = {NUM_PORTS{out_rsp_rdata_i}};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q  <= 1'b0;
      owner_q <= '0;
    end else if (out_req_valid_o && out_req_ready_i) begin
      lock_q  <= 1'b1;
      owner_q <= sel;
    end else if (out_rsp_valid_i && out_rsp_ready_o) begin
      lock_q  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/spm_bank.sv */
// Word-wide single-port bank; address bits above the window size are ignored, contents start undefined
`timescale 1ns/1ps
`default_nettype none

module spm_bank (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             req_valid_i,
  output logic                  req_ready_o,
  input  wire dspm_pkg::paddr_t addr_i,
  input  wire logic             we_i,
  input  wire dspm_pkg::be_t    be_i,
  input  wire dspm_pkg::word_t  wdata_i,
  output logic                  rsp_valid_o,
  input  wire logic             rsp_ready_i,
  output dspm_pkg::word_t       rsp_rdata_o
);

  import dspm_pkg::*;

  word_t    mem_q [SPM_WORDS];
  word_t    rdata_q;
  logic     rsp_valid_q;
  spm_idx_t idx;
  logic     req_fire;

  // Word index sits just above the byte offset
  assign idx      = addr_i[SPM_IDX_W+1:2];
  assign req_fire = req_valid_i && req_ready_o;

  // Only one response can be held at a time
  assign req_ready_o = !rsp_valid_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // ------------------------------
  // Array access
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (we_i) begin
        // Merge enabled bytes, stores answer with zero
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dspm_subsystem.sv */
// Two ports, one scratchpad bank and one bypass port; each port keeps at most one request open
`timescale 1ns/1ps
`default_nettype none

module dspm_subsystem (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  // Requester ports
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]             req_valid_i,
  output logic [dspm_pkg::NUM_PORTS-1:0]                  req_ready_o,
  input  wire dspm_pkg::paddr_t [dspm_pkg::NUM_PORTS-1:0] req_addr_i,
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]             req_we_i,
  input  wire dspm_pkg::be_t [dspm_pkg::NUM_PORTS-1:0]    req_be_i,
  input  wire dspm_pkg::word_t [dspm_pkg::NUM_PORTS-1:0]  req_wdata_i,
  output logic [dspm_pkg::NUM_PORTS-1:0]                  rsp_valid_o,
  input  wire logic [dspm_pkg::NUM_PORTS-1:0]             rsp_ready_i,
  output dspm_pkg::word_t [dspm_pkg::NUM_PORTS-1:0]       rsp_rdata_o,
  // Uncached bypass port
  output logic                                            mem_req_valid_o,
  input  wire logic                                       mem_req_ready_i,
  output dspm_pkg::paddr_t                                mem_req_addr_o,
  output logic                                            mem_req_we_o,
  output dspm_pkg::be_t                                   mem_req_be_o,
  output dspm_pkg::word_t                                 mem_req_wdata_o,
  input  wire logic                                       mem_rsp_valid_i,
  output logic                                            mem_rsp_ready_o,
  input  wire dspm_pkg::word_t                            mem_rsp_rdata_i
);

  import dspm_pkg::*;

  // ------------------------------
  // Router to arbiter wiring
  // ------------------------------
  logic   [NUM_PORTS-1:0] spm_req_valid;
  logic   [NUM_PORTS-1:0] spm_req_ready;
  logic   [NUM_PORTS-1:0] spm_rsp_valid;
  logic   [NUM_PORTS-1:0] spm_rsp_ready;
  word_t  [NUM_PORTS-1:0] spm_rsp_rdata;

  logic   [NUM_PORTS-1:0] byp_req_valid;
  logic   [NUM_PORTS-1:0] byp_req_ready;
  logic   [NUM_PORTS-1:0] byp_rsp_valid;
  logic   [NUM_PORTS-1:0] byp_rsp_ready;
  word_t  [NUM_PORTS-1:0] byp_rsp_rdata;

  // Held payload, read by both arbiters
  paddr_t [NUM_PORTS-1:0] fwd_addr;
  logic   [NUM_PORTS-1:0] fwd_we;
  be_t    [NUM_PORTS-1:0] fwd_be;
  word_t  [NUM_PORTS-1:0] fwd_wdata;

  // Scratchpad arbiter to bank
  logic                   bank_req_valid;
  logic                   bank_req_ready;
  paddr_t                 bank_addr;
  logic                   bank_we;
  be_t                    bank_be;
  word_t                  bank_wdata;
  logic                   bank_rsp_valid;
  logic                   bank_rsp_ready;
  word_t                  bank_rsp_rdata;

  port_router u_router0 (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i[0]),
    .req_ready_o     (req_ready_o[0]),
    .req_addr_i      (req_addr_i[0]),
    .req_we_i        (req_we_i[0]),
    .req_be_i        (req_be_i[0]),
    .req_wdata_i     (req_wdata_i[0]),
    .rsp_valid_o     (rsp_valid_o[0]),
    .rsp_ready_i     (rsp_ready_i[0]),
    .rsp_rdata_o     (rsp_rdata_o[0]),
    .spm_req_valid_o (spm_req_valid[0]),
    .spm_req_ready_i (spm_req_ready[0]),
    .spm_rsp_valid_i (spm_rsp_valid[0]),
    .spm_rsp_ready_o (spm_rsp_ready[0]),
    .spm_rsp_rdata_i (spm_rsp_rdata[0]),
    .byp_req_valid_o (byp_req_valid[0]),
    .byp_req_ready_i (byp_req_ready[0]),
    .byp_rsp_valid_i (byp_rsp_valid[0]),
    .byp_rsp_ready_o (byp_rsp_ready[0]),
    .byp_rsp_rdata_i (byp_rsp_rdata[0]),
    .fwd_addr_o      (fwd_addr[0]),
    .fwd_we_o        (fwd_we[0]),
    .fwd_be_o        (fwd_be[0]),
    .fwd_wdata_o     (fwd_wdata[0])
  );

  port_router u_router1 (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i[1]),
    .req_ready_o     (req_ready_o[1]),
    .req_addr_i      (req_addr_i[1]),
    .req_we_i        (req_we_i[1]),
    .req_be_i        (req_be_i[1]),
    .req_wdata_i     (req_wdata_i[1]),
    .rsp_valid_o     (rsp_valid_o[1]),
    .rsp_ready_i     (rsp_ready_i[1]),
    .rsp_rdata_o     (rsp_rdata_o[1]),
    .spm_req_valid_o (spm_req_valid[1]),
    .spm_req_ready_i (spm_req_ready[1]),
    .spm_rsp_valid_i (spm_rsp_valid[1]),
    .spm_rsp_ready_o (spm_rsp_ready[1]),
    .spm_rsp_rdata_i (spm_rsp_rdata[1]),
    .byp_req_valid_o (byp_req_valid[1]),
    .byp_req_ready_i (byp_req_ready[1]),
    .byp_rsp_valid_i (byp_rsp_valid[1]),
    .byp_rsp_ready_o (byp_rsp_ready[1]),
    .byp_rsp_rdata_i (byp_rsp_rdata[1]),
    .fwd_addr_o      (fwd_addr[1]),
    .fwd_we_o        (fwd_we[1]),
    .fwd_be_o        (fwd_be[1]),
    .fwd_wdata_o     (fwd_wdata[1])
  );

  // ------------------------------
  // Shared targets
  // ------------------------------
  mem_arbiter u_spm_arb (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .in_req_valid_i  (spm_req_valid),
    .in_req_ready_o  (spm_req_ready),
    .in_addr_i       (fwd_addr),
    .in_we_i         (fwd_we),
    .in_be_i         (fwd_be),
    .in_wdata_i      (fwd_wdata),
    .in_rsp_valid_o  (spm_rsp_valid),
    .in_rsp_ready_i  (spm_rsp_ready),
    .in_rsp_rdata_o  (spm_rsp_rdata),
    .out_req_valid_o (bank_req_valid),
    .out_req_ready_i (bank_req_ready),
    .out_addr_o      (bank_addr),
    .out_we_o        (bank_we),
    .out_be_o        (bank_be),
    .out_wdata_o     (bank_wdata),
    .out_rsp_valid_i (bank_rsp_valid),
    .out_rsp_ready_o (bank_rsp_ready),
    .out_rsp_rdata_i (bank_rsp_rdata)
  );

  // Target side is the bypass port itself
  mem_arbiter u_byp_arb (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .in_req_valid_i  (byp_req_valid),
    .in_req_ready_o  (byp_req_ready),
    .in_addr_i       (fwd_addr),
    .in_we_i         (fwd_we),
    .in_be_i         (fwd_be),
    .in_wdata_i      (fwd_wdata),
    .in_rsp_valid_o  (byp_rsp_valid),
    .in_rsp_ready_i  (byp_rsp_ready),
    .in_rsp_rdata_o  (byp_rsp_rdata),
    .out_req_valid_o (mem_req_valid_o),
    .out_req_ready_i (mem_req_ready_i),
    .out_addr_o      (mem_req_addr_o),
    .out_we_o        (mem_req_we_o),
    .out_be_o        (mem_req_be_o),
    .out_wdata_o     (mem_req_wdata_o),
    .out_rsp_valid_i (mem_rsp_valid_i),
    .out_rsp_ready_o (mem_rsp_ready_o),
    .out_rsp_rdata_i (mem_rsp_rdata_i)
  );

  spm_bank u_spm_bank (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (bank_req_valid),
    .req_ready_o (bank_req_ready),
    .addr_i      (bank_addr),
    .we_i        (bank_we),
    .be_i        (bank_be),
    .wdata_i     (bank_wdata),
    .rsp_valid_o (bank_rsp_valid),
    .rsp_ready_i (bank_rsp_ready),
    .rsp_rdata_o (bank_rsp_rdata)
  );

endmodule

`default_nettype wire

/* bench/tb_mem_model.sv */
// Bypass memory that serves one request at a time; loads return the address XOR a fixed key, stores 0
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter logic [31:0] SEED = 32'd1
) (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             req_valid_i,
  output logic                  req_ready_o,
  input  wire dspm_pkg::paddr_t req_addr_i,
  input  wire logic             req_we_i,
  output logic                  rsp_valid_o,
  input  wire logic             rsp_ready_i,
  output dspm_pkg::word_t       rsp_rdata_o,
  output int                    req_count_o
);

  import dspm_pkg::*;

  localparam int    DRIVE_DLY = 1;
  localparam word_t RD_KEY    = 32'hA5A5_5A5A;

  word_t  rng;
  paddr_t addr_q;
  logic   we_q;
  logic   taken;
  int     delay;

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_rdata_o = '0;
    req_count_o = 0;
    rng         = SEED;
    wait (arst_n_i === 1'b1);
    forever begin
      // Ready with random gaps until one request is taken
      taken = 1'b0;
      while (!taken) begin
        @(posedge clk_i);
        if (req_valid_i && req_ready_o) begin
          taken  = 1'b1;
          addr_q = req_addr_i;
          we_q   = req_we_i;
          req_count_o++;
        end
        #DRIVE_DLY;
        rng         = xorshift32(rng);
        req_ready_o = !taken && (rng[1:0] != 2'b00);
      end
      // Latency of zero to seven cycles
      delay = int'(rng[6:4]);
      while (delay > 0) begin
        @(posedge clk_i);
        #DRIVE_DLY;
        delay--;
      end
      rsp_valid_o = 1'b1;
      rsp_rdata_o = we_q ? '0 : (addr_q ^ RD_KEY);
      @(posedge clk_i);
      while (!rsp_ready_i) begin
        @(posedge clk_i);
      end
      #DRIVE_DLY;
      rsp_valid_o = 1'b0;
      rsp_rdata_o = '0;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_dspm_subsystem.sv */
// Each port keeps one operation open; the ports use disjoint 16-word spans of the scratchpad
`timescale 1ns/1ps
`default_nettype none

module tb_dspm_subsystem;

  import dspm_pkg::*;

  localparam int    CLK_PERIOD = 8;
  localparam int    DRIVE_DLY  = 1;
  localparam int    ROUNDS     = 150;
  localparam int    SPAN_WORDS = 16;
  localparam int    NUM_OPS    = 2 * ROUNDS + 2 * SPAN_WORDS + 16;
  localparam word_t SEED       = 32'd11748;
  localparam word_t RD_KEY     = 32'hA5A5_5A5A;

  logic                   clk_i;
  logic                   arst_n_i;
  logic   [NUM_PORTS-1:0] req_valid_i;
  logic   [NUM_PORTS-1:0] req_ready_o;
  paddr_t [NUM_PORTS-1:0] req_addr_i;
  logic   [NUM_PORTS-1:0] req_we_i;
  be_t    [NUM_PORTS-1:0] req_be_i;
  word_t  [NUM_PORTS-1:0] req_wdata_i;
  logic   [NUM_PORTS-1:0] rsp_valid_o;
  logic   [NUM_PORTS-1:0] rsp_ready_i;
  word_t  [NUM_PORTS-1:0] rsp_rdata_o;

  logic   mem_req_valid;
  logic   mem_req_ready;
  paddr_t mem_req_addr;
  logic   mem_req_we;
  be_t    mem_req_be;
  word_t  mem_req_wdata;
  logic   mem_rsp_valid;
  logic   mem_rsp_ready;
  word_t  mem_rsp_rdata;
  int     mem_count;

  // ------------------------------
  // Reference state
  // ------------------------------
  word_t  shadow     [SPM_WORDS];
  word_t  exp_rdata  [NUM_PORTS];
  word_t  last_rdata [NUM_PORTS];
  int     sent       [NUM_PORTS];
  int     rcvd       [NUM_PORTS];
  paddr_t byp_addr   [NUM_PORTS];
  logic   byp_we     [NUM_PORTS];
  be_t    byp_be     [NUM_PORTS];
  word_t  byp_wdata  [NUM_PORTS];
  int     byp_issued [NUM_PORTS];
  int     byp_seen   [NUM_PORTS];
  logic   held_q     [NUM_PORTS];
  word_t  held_data  [NUM_PORTS];
  word_t  rng_state  [NUM_PORTS];
  word_t  rdy_rng;
  logic   hold_ready;
  int     n_checks = 0;
  int     n_errors = 0;

  dspm_subsystem dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .req_we_i        (req_we_i),
    .req_be_i        (req_be_i),
    .req_wdata_i     (req_wdata_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_rdata_o     (rsp_rdata_o),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_we_o    (mem_req_we),
    .mem_req_be_o    (mem_req_be),
    .mem_req_wdata_o (mem_req_wdata),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready),
    .mem_rsp_rdata_i (mem_rsp_rdata)
  );

  tb_mem_model #(
    .SEED (SEED ^ 32'h0000_FFFF)
  ) u_mem (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_addr_i  (mem_req_addr),
    .req_we_i    (mem_req_we),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_ready_i (mem_rsp_ready),
    .rsp_rdata_o (mem_rsp_rdata),
    .req_count_o (mem_count)
  );

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_window(input paddr_t a);
    return (a >= SPM_BASE) && (a < SPM_BASE + paddr_t'(SPM_WORDS * 4));
  endfunction

  function automatic paddr_t spm_addr(input int idx);
    return SPM_BASE + paddr_t'(idx * 4);
  endfunction

  function automatic word_t expected_rdata(input paddr_t a, input logic we);
    if (we) begin
      return '0;
    end
    if (in_window(a)) begin
      return shadow[a[9:2]];
    end
    return a ^ RD_KEY;
  endfunction

  task automatic check_value(input word_t got, input word_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Runs one operation on port p and returns 1 ns after its response is taken
  task automatic run_op(input int p, input paddr_t addr, input logic we, input be_t be,
                        input word_t wdata, output int lat);
    exp_rdata[p] = expected_rdata(addr, we);
    if (we && in_window(addr)) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    if (!in_window(addr)) begin
      byp_addr[p]  = addr;
      byp_we[p]    = we;
      byp_be[p]    = be;
      byp_wdata[p] = wdata;
      byp_issued[p]++;
    end
    sent[p]++;
    req_valid_i[p] = 1'b1;
    req_addr_i[p]  = addr;
    req_we_i[p]    = we;
    req_be_i[p]    = be;
    req_wdata_i[p] = wdata;
    @(posedge clk_i);
    while (!req_ready_o[p]) begin
      @(posedge clk_i);
    end
    // Count edges from the request handshake to the first valid response
    lat = 0;
    do begin
      if (lat == 0) begin
        #DRIVE_DLY;
        req_valid_i[p] = 1'b0;
      end
      @(posedge clk_i);
      lat++;
    end while (!rsp_valid_o[p]);
    #DRIVE_DLY;
    while (rcvd[p] < sent[p]) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
  endtask

  task automatic random_op(input int p);
    word_t  r;
    word_t  ar;
    word_t  d;
    paddr_t a;
    int     lat;
    rng_state[p] = xorshift32(rng_state[p]);
    r            = rng_state[p];
    rng_state[p] = xorshift32(rng_state[p]);
    ar           = rng_state[p];
    rng_state[p] = xorshift32(rng_state[p]);
    d            = rng_state[p];
    if (r[3:0] < 4'd6) begin
      a = {ar[31:2], 2'b00};
      if (in_window(a)) begin
        a[31] = 1'b1;
      end
    end else begin
      a = spm_addr(p * 128 + int'(r[15:12]));
    end
    run_op(p, a, r[4], r[11:8], d, lat);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Random response back-pressure unless held high
  initial begin : ready_drive
    rsp_ready_i = '1;
    rdy_rng     = SEED ^ 32'h00FF_0000;
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      if (hold_ready) begin
        rsp_ready_i = '1;
      end else begin
        rdy_rng     = xorshift32(rdy_rng);
        rsp_ready_i = {rdy_rng[5:4] != 2'b00, rdy_rng[1:0] != 2'b00};
      end
    end
  end

  // ------------------------------
  // Compare process
  // ------------------------------
  initial begin : monitor
    logic found;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rcvd[p]       = 0;
      byp_seen[p]   = 0;
      held_q[p]     = 1'b0;
      last_rdata[p] = '0;
    end
    forever begin
      @(posedge clk_i);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (held_q[p]) begin
          check_value(word_t'(rsp_valid_o[p]), 32'd1,
                      $sformatf("port %0d response withdrawn while stalled", p));
          check_value(rsp_rdata_o[p], held_data[p],
                      $sformatf("port %0d response data changed while stalled", p));
        end
        held_q[p]    = rsp_valid_o[p] && !rsp_ready_i[p];
        held_data[p] = rsp_rdata_o[p];
        if (rsp_valid_o[p] && rsp_ready_i[p]) begin
          if (rcvd[p] >= sent[p]) begin
            n_errors++;
            $display("Port %0d gave a response with no request open at %0t ns", p, $time);
          end else begin
            check_value(rsp_rdata_o[p], exp_rdata[p], $sformatf("port %0d read data", p));
          end
          last_rdata[p] = rsp_rdata_o[p];
          rcvd[p]++;
        end
      end
      if (mem_req_valid && mem_req_ready) begin
        found = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (!found && byp_seen[p] < byp_issued[p] && mem_req_addr == byp_addr[p] &&
              mem_req_we == byp_we[p] && mem_req_be == byp_be[p] &&
              mem_req_wdata == byp_wdata[p]) begin
            found = 1'b1;
            byp_seen[p]++;
          end
        end
        if (!found) begin
          n_errors++;
          $display("Bypass request to %h at %0t ns matches no open bypass operation",
                   mem_req_addr, $time);
        end
      end
    end
  end

  initial begin : watchdog
    #(NUM_OPS * 200 * CLK_PERIOD);
    $display("Run timed out after %0d cycles, %0d errors so far", NUM_OPS * 200, n_errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int lat0;
    int lat1;
    arst_n_i    = 1'b0;
    req_valid_i = '0;
    req_addr_i  = '0;
    req_we_i    = '0;
    req_be_i    = '0;
    req_wdata_i = '0;
    hold_ready  = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      sent[p]       = 0;
      byp_issued[p] = 0;
      rng_state[p]  = SEED ^ word_t'(p << 16);
    end
    repeat (16) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    check_value(word_t'(req_ready_o), word_t'({NUM_PORTS{1'b1}}), "req_ready_o after reset");
    check_value(word_t'(rsp_valid_o), 32'd0, "rsp_valid_o after reset");
    check_value(word_t'(mem_req_valid), 32'd0, "mem_req_valid_o after reset");

    // Fill both spans so every later load hits a known word
    for (int w = 0; w < SPAN_WORDS; w++) begin
      fork
        run_op(0, spm_addr(w), 1'b1, 4'hF, spm_addr(w) ^ 32'h3C3C_0000, lat0);
        run_op(1, spm_addr(128 + w), 1'b1, 4'hF, spm_addr(128 + w) ^ 32'h3C3C_0000, lat1);
      join
    end

    // Partial store merge and the uncontended load latency
    run_op(0, spm_addr(5), 1'b1, 4'hF, 32'h1122_3344, lat0);
    run_op(0, spm_addr(5), 1'b1, 4'b0101, 32'hAABB_CCDD, lat0);
    run_op(0, spm_addr(5), 1'b0, 4'hF, 32'h0, lat0);
    check_value(last_rdata[0], 32'h11BB_33DD, "merged scratchpad word");
    check_value(word_t'(lat0), 32'd2, "scratchpad load latency in cycles");

    // Bypass accesses around the window edges
    run_op(1, 32'h0000_4000, 1'b0, 4'hF, 32'h0, lat1);
    run_op(1, SPM_BASE - 32'd4, 1'b1, 4'b1100, 32'hCAFE_F00D, lat1);
    run_op(1, SPM_BASE + paddr_t'(SPM_WORDS * 4), 1'b0, 4'hF, 32'h0, lat1);

    // Concurrent random traffic under back-pressure
    hold_ready = 1'b0;
    for (int i = 0; i < ROUNDS; i++) begin
      fork
        random_op(0);
        random_op(1);
      join
    end
    hold_ready = 1'b1;
    repeat (10) @(posedge clk_i);

    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value(word_t'(rcvd[p]), word_t'(sent[p]), $sformatf("port %0d response count", p));
      check_value(word_t'(byp_seen[p]), word_t'(byp_issued[p]),
                  $sformatf("port %0d bypass requests seen", p));
    end
    check_value(word_t'(mem_count), word_t'(byp_issued[0] + byp_issued[1]),
                "bypass requests counted by the memory model");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/dspm_pkg.sv
hw/port_router.sv
hw/mem_arbiter.sv
hw/spm_bank.sv
hw/dspm_subsystem.sv
bench/tb_mem_model.sv
bench/tb_dspm_subsystem.sv

/* Bender.yml */
package:
  name: dspm_subsystem

sources:
  - files:
      - hw/dspm_pkg.sv
      - hw/port_router.sv
      - hw/mem_arbiter.sv
      - hw/spm_bank.sv
      - hw/dspm_subsystem.sv
  - target: test
    files:
      - bench/tb_mem_model.sv
      - bench/tb_dspm_subsystem.sv
